/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // widths with a meaning in the ISA
  typedef logic [15:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [2:0]  reg_idx_t;
  typedef logic [4:0]  opcode_t;

  // opcodes with bit 4 clear, the immediate forms set it
  localparam opcode_t OP_MV   = 5'b00000;
  localparam opcode_t OP_ADD  = 5'b00001;
  localparam opcode_t OP_SUB  = 5'b00010;
  localparam opcode_t OP_CMP  = 5'b00011;
  localparam opcode_t OP_LD   = 5'b00100;
  localparam opcode_t OP_ST   = 5'b00101;
  localparam opcode_t OP_NOP  = 5'b00111;
  localparam opcode_t OP_CALL = 5'b01100;
  localparam opcode_t OP_MVHI = 5'b10110;

  // full nop word used as the reset value of the pipeline registers
  localparam instr_t NOP_INSTR = {11'd0, OP_NOP};

  // call stores its return address here
  localparam reg_idx_t LINK_REG = 3'd7;

  // operand A sources
  localparam logic [1:0] A_SEL_FWD = 2'd0;
  localparam logic [1:0] A_SEL_RF  = 2'd1;

  // operand B sources
  localparam logic [1:0] B_SEL_FWD = 2'd0;
  localparam logic [1:0] B_SEL_IMM = 2'd1;
  localparam logic [1:0] B_SEL_RF  = 2'd2;

  typedef struct packed {
    instr_t ir;
    word_t  pc;
    word_t  datax;
    word_t  datay;
  } ex_bundle_t;

  typedef struct packed {
    logic       alu_r_ld;
    logic       alu_n_ld;
    logic       alu_z_ld;
    logic [1:0] alu_a_sel;
    logic [1:0] alu_b_sel;
    logic       alu_op_sel;
    logic       ldst_rd;
    logic       ldst_wr;
  } ex_ctrl_t;

  typedef struct packed {
    logic  rd;
    logic  wr;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    word_t    data;
  } rf_write_t;

  typedef struct packed {
    instr_t ir;
    word_t  pc;
    word_t  x;
    word_t  b;
    word_t  alu_r;
  } wb_bundle_t;

  // mv/mvi, add/addi, sub/subi, ld and mvhi write Rx
  function automatic logic writes_rx(opcode_t op);
    logic hit;
    hit = (op[3:0] == OP_MV[3:0]) || (op[3:0] == OP_ADD[3:0]) ||
          (op[3:0] == OP_SUB[3:0]) || (op == OP_LD) || (op == OP_MVHI);
    return hit;
  endfunction

  // callr and call write the link register
  function automatic logic writes_link(opcode_t op);
    return op[3:0] == OP_CALL[3:0];
  endfunction

endpackage

`default_nettype wire

/* hw/cpu_execute_top.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_execute_top (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  cpu_pkg::instr_t    i_ir,
  input  cpu_pkg::word_t     i_pc,
  input  cpu_pkg::word_t     i_ldst_rddata,
  output cpu_pkg::mem_req_t  o_mem_req,
  output cpu_pkg::rf_write_t o_rf_write,
  output logic               o_flag_n,
  output logic               o_flag_z
);

  // stage to stage buses
  cpu_pkg::ex_bundle_t ex;
  cpu_pkg::ex_ctrl_t   ctrl;
  cpu_pkg::wb_bundle_t wb_next;

  // writeback feedback paths
  cpu_pkg::instr_t     ir_wr;
  cpu_pkg::word_t      fwd;
  cpu_pkg::rf_write_t  rf_write;

  cpu_operand_fetch i_cpu_operand_fetch (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ir       (i_ir),
    .i_pc       (i_pc),
    .i_rf_write (rf_write),
    .o_ex       (ex)
  );

  cpu_execute_control i_cpu_execute_control (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ir_ex (ex.ir),
    .i_ir_wr (ir_wr),
    .o_ctrl  (ctrl)
  );

  cpu_execute_datapath i_cpu_execute_datapath (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_ex      (ex),
    .i_ctrl    (ctrl),
    .i_fwd     (fwd),
    .o_mem_req (o_mem_req),
    .o_wb_next (wb_next),
    .o_flag_n  (o_flag_n),
    .o_flag_z  (o_flag_z)
  );

  cpu_writeback i_cpu_writeback (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_wb_next     (wb_next),
    .i_ldst_rddata (i_ldst_rddata),
    .o_ir_wr       (ir_wr),
    .o_fwd         (fwd),
    .o_rf_write    (rf_write)
  );

  assign o_rf_write = rf_write;

endmodule

`default_nettype wire

/* hw/cpu_operand_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_operand_fetch (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  cpu_pkg::instr_t     i_ir,
  input  cpu_pkg::word_t      i_pc,
  input  cpu_pkg::rf_write_t  i_rf_write,
  output cpu_pkg::ex_bundle_t o_ex
);

  // eight architectural registers
  cpu_pkg::word_t    rf [8];

  cpu_pkg::reg_idx_t rx_idx;
  cpu_pkg::reg_idx_t ry_idx;
  cpu_pkg::word_t    rx_data;
  cpu_pkg::word_t    ry_data;

  // execute stage input register
  cpu_pkg::instr_t   ex_ir_q;
  cpu_pkg::word_t    ex_pc_q;
  cpu_pkg::word_t    ex_datax_q;
  cpu_pkg::word_t    ex_datay_q;

  assign rx_idx = i_ir[7:5];
  assign ry_idx = i_ir[10:8];

  // write port driven by writeback
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 8; i++) begin
        rf[i] <= '0;
      end
    end else if (i_rf_write.en) begin
      rf[i_rf_write.idx] <= i_rf_write.data;
    end
  end

  // write-through bypass covers the hazard two instructions apart
  assign rx_data = (i_rf_write.en && (i_rf_write.idx == rx_idx)) ? i_rf_write.data :
                   rf[rx_idx];
  assign ry_data = (i_rf_write.en && (i_rf_write.idx == ry_idx)) ? i_rf_write.data :
                   rf[ry_idx];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ex_ir_q <= cpu_pkg::NOP_INSTR;
    end else begin
      ex_ir_q <= i_ir;
    end
  end

  // operand payload, captured every clock
  always_ff @(posedge i_clk) begin
    ex_pc_q    <= i_pc;
    ex_datax_q <= rx_data;
    ex_datay_q <= ry_data;
  end

  assign o_ex = '{ir: ex_ir_q, pc: ex_pc_q, datax: ex_datax_q, datay: ex_datay_q};

endmodule

`default_nettype wire

/* hw/cpu_writeback.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_writeback (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  cpu_pkg::wb_bundle_t i_wb_next,
  input  cpu_pkg::word_t      i_ldst_rddata,
  output cpu_pkg::instr_t     o_ir_wr,
  output cpu_pkg::word_t      o_fwd,
  output cpu_pkg::rf_write_t  o_rf_write
);

  cpu_pkg::instr_t  ir_q;
  cpu_pkg::word_t   pc_q;
  cpu_pkg::word_t   x_q;
  cpu_pkg::word_t   b_q;
  cpu_pkg::word_t   alu_r_q;

  cpu_pkg::opcode_t op;
  cpu_pkg::word_t   result;
  logic             link;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ir_q <= cpu_pkg::NOP_INSTR;
    end else begin
      ir_q <= i_wb_next.ir;
    end
  end

  always_ff @(posedge i_clk) begin
    pc_q    <= i_wb_next.pc;
    x_q     <= i_wb_next.x;
    b_q     <= i_wb_next.b;
    alu_r_q <= i_wb_next.alu_r;
  end

  assign op   = ir_q[4:0];
  assign link = cpu_pkg::writes_link(op);

  // immediate or register form picks the same source
  always_comb begin
    case (op[3:0])
      cpu_pkg::OP_MV[3:0]:   result = b_q;
      cpu_pkg::OP_LD[3:0]:   result = i_ldst_rddata;
      cpu_pkg::OP_MVHI[3:0]: result = {ir_q[15:8], x_q[7:0]};
      cpu_pkg::OP_CALL[3:0]: result = pc_q;
      default:               result = alu_r_q;
    endcase
  end

  assign o_ir_wr = ir_q;
  // also feeds the execute forwarding muxes
  assign o_fwd   = result;

  assign o_rf_write = '{
    en:   cpu_pkg::writes_rx(op) || link,
    idx:  link ? cpu_pkg::LINK_REG : ir_q[7:5],
    data: result
  };

  // load data or ALU result must be settled when a write happens
  a_write_data_known: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      o_rf_write.en |-> !$isunknown(o_rf_write.data)
  );

endmodule

`default_nettype wire

/* hw/execute/cpu_execute_control.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_execute_control (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  cpu_pkg::instr_t   i_ir_ex,
  input  cpu_pkg::instr_t   i_ir_wr,
  output cpu_pkg::ex_ctrl_t o_ctrl
);

  cpu_pkg::opcode_t  op_ex;
  cpu_pkg::opcode_t  op_wr;

  // writeback side of the hazard check
  logic              prev_rx;
  logic              prev_r7;
  cpu_pkg::reg_idx_t prev_idx;

  // execute side of the hazard check
  logic              curr_rx;
  logic              curr_ry;
  logic              is_alu;

  logic              fw_rx;
  logic              fw_ry;

  cpu_pkg::ex_ctrl_t ctrl;

  assign op_ex = i_ir_ex[4:0];
  assign op_wr = i_ir_wr[4:0];

  always_comb begin
    // instruction in writeback targets Rx or the link register
    prev_rx  = cpu_pkg::writes_rx(op_wr);
    prev_r7  = cpu_pkg::writes_link(op_wr);
    prev_idx = prev_r7 ? cpu_pkg::LINK_REG : i_ir_wr[7:5];

    // add, sub, cmp in either form
    is_alu = (op_ex[3:0] == cpu_pkg::OP_ADD[3:0]) ||
             (op_ex[3:0] == cpu_pkg::OP_SUB[3:0]) ||
             (op_ex[3:0] == cpu_pkg::OP_CMP[3:0]);

    // st reads Rx as store data and mvhi keeps the low byte of Rx
    curr_rx = is_alu || (op_ex == cpu_pkg::OP_ST) || (op_ex == cpu_pkg::OP_MVHI);

    // register forms 00000 to 00011 plus ld/st addresses
    curr_ry = !op_ex[4] && (op_ex[3:0] <= cpu_pkg::OP_ST[3:0]);

    fw_rx = curr_rx && (prev_rx || prev_r7) && (i_ir_ex[7:5] == prev_idx);
    fw_ry = curr_ry && (prev_rx || prev_r7) && (i_ir_ex[10:8] == prev_idx);

    // defaults read straight from the register file copies
    ctrl            = '0;
    ctrl.alu_a_sel  = cpu_pkg::A_SEL_RF;
    ctrl.alu_b_sel  = cpu_pkg::B_SEL_RF;

    if (curr_rx) begin
      ctrl.alu_a_sel = fw_rx ? cpu_pkg::A_SEL_FWD : cpu_pkg::A_SEL_RF;
    end

    // immediate forms take the sign extended byte
    if (curr_ry) begin
      ctrl.alu_b_sel = fw_ry ? cpu_pkg::B_SEL_FWD : cpu_pkg::B_SEL_RF;
    end else if (op_ex[4]) begin
      ctrl.alu_b_sel = cpu_pkg::B_SEL_IMM;
    end

    if (is_alu) begin
      ctrl.alu_r_ld   = 1'b1;
      ctrl.alu_n_ld   = 1'b1;
      ctrl.alu_z_ld   = 1'b1;
      // bit 1 set for sub and cmp
      ctrl.alu_op_sel = op_ex[1];
    end

    ctrl.ldst_rd = (op_ex == cpu_pkg::OP_LD);
    ctrl.ldst_wr = (op_ex == cpu_pkg::OP_ST);
  end

  assign o_ctrl = ctrl;

  // selects and strobes never undefined once out of reset
  a_ctrl_known: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      !$isunknown(o_ctrl)
  );

endmodule

`default_nettype wire

/* hw/execute/cpu_execute_datapath.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_execute_datapath (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  cpu_pkg::ex_bundle_t i_ex,
  input  cpu_pkg::ex_ctrl_t   i_ctrl,
  input  cpu_pkg::word_t      i_fwd,
  output cpu_pkg::mem_req_t   o_mem_req,
  output cpu_pkg::wb_bundle_t o_wb_next,
  output logic                o_flag_n,
  output logic                o_flag_z
);

  cpu_pkg::word_t imm_ext;
  cpu_pkg::word_t opnd_x;
  cpu_pkg::word_t opnd_b;
  cpu_pkg::word_t alu_out;
  cpu_pkg::word_t alu_r_next;

  // last ALU result
  cpu_pkg::word_t alu_r_q;

  logic           flag_n_q;
  logic           flag_z_q;

  // signed byte in 15:8
  assign imm_ext = {{8{i_ex.ir[15]}}, i_ex.ir[15:8]};

  always_comb begin
    case (i_ctrl.alu_a_sel)
      cpu_pkg::A_SEL_FWD: opnd_x = i_fwd;
      default:            opnd_x = i_ex.datax;
    endcase
  end

  always_comb begin
    case (i_ctrl.alu_b_sel)
      cpu_pkg::B_SEL_FWD: opnd_b = i_fwd;
      cpu_pkg::B_SEL_IMM: opnd_b = imm_ext;
      default:            opnd_b = i_ex.datay;
    endcase
  end

  // sub and cmp share the subtractor
  assign alu_out = i_ctrl.alu_op_sel ? (opnd_x - opnd_b) : (opnd_x + opnd_b);

  // alu_r holds unless an ALU op loads it
  assign alu_r_next = i_ctrl.alu_r_ld ? alu_out : alu_r_q;

  always_ff @(posedge i_clk) begin
    alu_r_q <= alu_r_next;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      flag_n_q <= 1'b0;
      flag_z_q <= 1'b0;
    end else begin
      if (i_ctrl.alu_n_ld) begin
        flag_n_q <= alu_out[15];
      end
      if (i_ctrl.alu_z_ld) begin
        flag_z_q <= (alu_out == '0);
      end
    end
  end

  assign o_flag_n = flag_n_q;
  assign o_flag_z = flag_z_q;

  // Ry addresses memory, Rx supplies store data
  assign o_mem_req = '{
    rd:    i_ctrl.ldst_rd,
    wr:    i_ctrl.ldst_wr,
    addr:  opnd_b,
    wdata: opnd_x
  };

  // writeback captures this on the same edge as alu_r
  assign o_wb_next = '{
    ir:    i_ex.ir,
    pc:    i_ex.pc,
    x:     opnd_x,
    b:     opnd_b,
    alu_r: alu_r_next
  };

  // ALU and load/store decode must stay disjoint
  a_no_mem_on_alu: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      i_ctrl.alu_r_ld |-> !(o_mem_req.rd || o_mem_req.wr)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the execute/writeback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cpu_execute -f vlog.f -o tb_cpu_execute
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_cpu_execute)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

/* verification/cpu_execute_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_execute_checker (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  cpu_pkg::instr_t    i_ir,
  input  cpu_pkg::word_t     i_pc,
  input  cpu_pkg::mem_req_t  i_mem_req,
  input  cpu_pkg::rf_write_t i_rf_write,
  input  logic               i_flag_n,
  input  logic               i_flag_z,
  output logic               o_drained,
  output int                 o_errors,
  output int                 o_checks
);

  // expected writeback port and flags for one issued instruction
  typedef struct packed {
    logic               live;
    cpu_pkg::rf_write_t wr;
    logic               n;
    logic               z;
  } wb_exp_t;

  // architectural state of the model
  cpu_pkg::word_t    arch_rf [8];
  logic              arch_n;
  logic              arch_z;

  // expectations one and two cycles after capture
  cpu_pkg::mem_req_t mem_exp;
  wb_exp_t           wb_q1;
  wb_exp_t           wb_q2;

  int                errors = 0;
  int                checks = 0;

  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s at %0t: got 0x%h expected 0x%h", name, $time, got, exp);
    end
  endtask

  // runs one instruction on the model in issue order
  task automatic step_model(input cpu_pkg::instr_t ir, input cpu_pkg::word_t pc);
    logic [4:0]        op;
    logic [2:0]        rx;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    vx;
    cpu_pkg::word_t    vb;
    cpu_pkg::word_t    res;
    logic              wen;
    logic [2:0]        widx;
    cpu_pkg::word_t    wdata;
    op    = ir[4:0];
    rx    = ir[7:5];
    imm   = {{8{ir[15]}}, ir[15:8]};
    vx    = arch_rf[rx];
    // immediate forms use the byte in place of Ry
    vb    = op[4] ? imm : arch_rf[ir[10:8]];
    res   = '0;
    wen   = 1'b0;
    widx  = rx;
    wdata = '0;
    mem_exp = '0;
    case (op)
      5'b00000, 5'b10000: begin
        wen   = 1'b1;
        wdata = vb;
      end
      5'b00001, 5'b10001, 5'b00010, 5'b10010, 5'b00011, 5'b10011: begin
        res    = (op[1:0] == 2'b01) ? vx + vb : vx - vb;
        arch_n = res[15];
        arch_z = (res == 16'h0000);
        // cmp only touches the flags
        wen    = (op[1:0] != 2'b11);
        wdata  = res;
      end
      5'b00100: begin
        mem_exp.rd   = 1'b1;
        mem_exp.addr = vb;
        // memory model answers with the address xor 5A5A
        wen          = 1'b1;
        wdata        = vb ^ 16'h5A5A;
      end
      5'b00101: begin
        mem_exp.wr    = 1'b1;
        mem_exp.addr  = vb;
        mem_exp.wdata = vx;
      end
      5'b10110: begin
        wen   = 1'b1;
        wdata = {ir[15:8], vx[7:0]};
      end
      5'b01100: begin
        wen   = 1'b1;
        widx  = 3'd7;
        wdata = pc;
      end
      default: begin
      end
    endcase
    if (wen) begin
      arch_rf[widx] = wdata;
    end
    wb_q1.live    = (op != 5'b00111);
    wb_q1.wr.en   = wen;
    wb_q1.wr.idx  = widx;
    wb_q1.wr.data = wdata;
    wb_q1.n       = arch_n;
    wb_q1.z       = arch_z;
  endtask

  // falling edge, inputs and outputs are both settled here
  always @(negedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 8; i++) begin
        arch_rf[i] = '0;
      end
      arch_n  = 1'b0;
      arch_z  = 1'b0;
      mem_exp = '0;
      wb_q1   = '0;
      wb_q2   = '0;
    end else begin
      compare_field("o_mem_req.rd", 16'(i_mem_req.rd), 16'(mem_exp.rd));
      compare_field("o_mem_req.wr", 16'(i_mem_req.wr), 16'(mem_exp.wr));
      if (mem_exp.rd || mem_exp.wr) begin
        compare_field("o_mem_req.addr", i_mem_req.addr, mem_exp.addr);
      end
      if (mem_exp.wr) begin
        compare_field("o_mem_req.wdata", i_mem_req.wdata, mem_exp.wdata);
      end
      compare_field("o_rf_write.en", 16'(i_rf_write.en), 16'(wb_q2.wr.en));
      // index and data only matter on a write
      if (wb_q2.wr.en) begin
        compare_field("o_rf_write.idx", 16'(i_rf_write.idx), 16'(wb_q2.wr.idx));
        compare_field("o_rf_write.data", i_rf_write.data, wb_q2.wr.data);
      end
      compare_field("o_flag_n", 16'(i_flag_n), 16'(wb_q2.n));
      compare_field("o_flag_z", 16'(i_flag_z), 16'(wb_q2.z));
      wb_q2 = wb_q1;
      step_model(i_ir, i_pc);
    end
  end

  assign o_drained = !wb_q1.live && !wb_q2.live;
  assign o_errors  = errors;
  assign o_checks  = checks;

endmodule

`default_nettype wire

/* verification/tb_cpu_execute.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_cpu_execute;

  localparam int              SEED        = 62819;
  localparam int              RAND_ROWS   = 40;
  localparam int              DRAIN_LIMIT = 20;
  localparam cpu_pkg::instr_t NOP         = cpu_pkg::NOP_INSTR;

  // one issue slot of the stimulus table
  typedef struct packed {
    cpu_pkg::instr_t ir;
    cpu_pkg::word_t  pc;
  } row_t;

  logic               clk = 1'b0;
  logic               rst_n = 1'b0;
  cpu_pkg::instr_t    ir;
  cpu_pkg::word_t     pc;
  cpu_pkg::word_t     ldst_rddata = '0;
  cpu_pkg::mem_req_t  mem_req;
  cpu_pkg::rf_write_t rf_write;
  logic               flag_n;
  logic               flag_z;

  logic               drained;
  int                 chk_errors;
  int                 chk_count;
  int                 tb_errors;
  int                 wait_cnt;
  row_t               stim_q [$];
  cpu_pkg::word_t     pc_next;

  always #10 clk = ~clk;

  cpu_execute_top i_cpu_execute_top (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_ir          (ir),
    .i_pc          (pc),
    .i_ldst_rddata (ldst_rddata),
    .o_mem_req     (mem_req),
    .o_rf_write    (rf_write),
    .o_flag_n      (flag_n),
    .o_flag_z      (flag_z)
  );

  cpu_execute_checker chk (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_ir       (ir),
    .i_pc       (pc),
    .i_mem_req  (mem_req),
    .i_rf_write (rf_write),
    .i_flag_n   (flag_n),
    .i_flag_z   (flag_z),
    .o_drained  (drained),
    .o_errors   (chk_errors),
    .o_checks   (chk_count)
  );

  // synchronous read memory, data shows up one edge after the request
  always @(posedge clk) begin
    if (mem_req.rd) begin
      ldst_rddata <= mem_req.addr ^ 16'h5A5A;
    end
  end

  function automatic cpu_pkg::instr_t reg_form(cpu_pkg::opcode_t op, int rx, int ry);
    return {5'd0, ry[2:0], rx[2:0], op};
  endfunction

  // bit 4 marks the immediate form
  function automatic cpu_pkg::instr_t imm_form(cpu_pkg::opcode_t op, int rx, int imm);
    return {imm[7:0], rx[2:0], 1'b1, op[3:0]};
  endfunction

  task automatic push_row(input cpu_pkg::instr_t row_ir);
    stim_q.push_back('{ir: row_ir, pc: pc_next});
    pc_next = pc_next + 16'd2;
  endtask

  task automatic fill_table();
    logic [31:0]      rnd;
    cpu_pkg::opcode_t op;
    // idle slots right after reset
    push_row(NOP);
    push_row(NOP);
    push_row(NOP);
    push_row(imm_form(cpu_pkg::OP_MV, 1, 5));
    push_row(imm_form(cpu_pkg::OP_MV, 2, -3));
    // r1 two apart, r2 one apart through Ry
    push_row(reg_form(cpu_pkg::OP_ADD, 1, 2));
    push_row(reg_form(cpu_pkg::OP_SUB, 1, 2));
    push_row(reg_form(cpu_pkg::OP_CMP, 1, 1));
    push_row(imm_form(cpu_pkg::OP_ADD, 3, -128));
    push_row(imm_form(cpu_pkg::OP_SUB, 3, 1));
    push_row(imm_form(cpu_pkg::OP_CMP, 2, -3));
    push_row(reg_form(cpu_pkg::OP_MV, 4, 3));
    push_row(reg_form(cpu_pkg::OP_MV, 5, 4));
    push_row(reg_form(cpu_pkg::OP_CALL, 0, 0));
    // link register forwarded through Ry, then through Rx
    push_row(reg_form(cpu_pkg::OP_ADD, 5, 7));
    push_row(reg_form(cpu_pkg::OP_CALL, 0, 0));
    push_row(imm_form(cpu_pkg::OP_MVHI, 7, 8'h3C));
    push_row(NOP);
    push_row(imm_form(cpu_pkg::OP_MV, 6, 8'h40));
    push_row(reg_form(cpu_pkg::OP_ST, 5, 6));
    push_row(reg_form(cpu_pkg::OP_LD, 0, 6));
    // load result forwarded into both operands
    push_row(reg_form(cpu_pkg::OP_ADD, 0, 0));
    push_row(reg_form(cpu_pkg::OP_LD, 2, 0));
    push_row(NOP);
    push_row(reg_form(cpu_pkg::OP_ADD, 2, 1));
    push_row(reg_form(cpu_pkg::OP_ST, 2, 3));
    push_row(imm_form(cpu_pkg::OP_MVHI, 4, 8'hA5));
    push_row(reg_form(cpu_pkg::OP_MV, 1, 4));
    push_row(reg_form(cpu_pkg::OP_CMP, 1, 4));
    push_row(NOP);
    push_row(NOP);
    // random mv, add, sub, cmp in both forms
    for (int i = 0; i < RAND_ROWS; i++) begin
      rnd = $urandom;
      op  = {rnd[2], 2'b00, rnd[1:0]};
      if (rnd[2]) begin
        push_row({rnd[15:8], rnd[7:5], op});
      end else begin
        push_row({5'd0, rnd[10:8], rnd[7:5], op});
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    ir        <= NOP;
    pc        <= '0;
    tb_errors = 0;
    pc_next   = 16'h0100;
    fill_table();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (stim_q[i]) begin
      @(posedge clk);
      ir <= stim_q[i].ir;
      pc <= stim_q[i].pc;
    end
    @(posedge clk);
    ir <= NOP;
    // let the last instructions leave writeback
    wait_cnt = 0;
    while (!drained && wait_cnt < DRAIN_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!drained) begin
      tb_errors++;
      $display("pipeline still busy %0d cycles after the last instruction", DRAIN_LIMIT);
    end
    $display("checks %0d, check errors %0d, other errors %0d",
             chk_count, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/cpu_pkg.sv
hw/cpu_operand_fetch.sv
hw/execute/cpu_execute_control.sv
hw/execute/cpu_execute_datapath.sv
hw/cpu_writeback.sv
hw/cpu_execute_top.sv
verification/cpu_execute_checker.sv
verification/tb_cpu_execute.sv
